//--- apb_dram_port.sv
`timescale 1ns/100ps

module apb_dram_port (
    input  logic                              CLK,
    input  logic                              nRST,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [dram_addr_pkg::ADDR_W-1:0]  paddr,
    input  dram_addr_pkg::data_t              pwdata,
    input  logic                              ram_wait,
    input  dram_addr_pkg::data_t              dram_rdata,
    input  logic                              tRD_done,
    output dram_addr_pkg::data_t              prdata,
    output logic                              pready,
    output logic                              dWEN,
    output logic                              dREN,
    output dram_addr_pkg::bank_t              req_bank,
    output dram_addr_pkg::row_t               req_row,
    output dram_addr_pkg::col_t               req_col
);
    logic setup;

    // a new transfer is only accepted while nothing is outstanding
    assign setup = psel && !penable && !dWEN && !dREN;

    // the FSM drops ram_wait for one cycle when the request is finished
    assign pready = (dWEN || dREN) && !ram_wait;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            dWEN <= 1'b0;
            dREN <= 1'b0;
        end else if (pready) begin
            dWEN <= 1'b0;
            dREN <= 1'b0;
        end else if (setup) begin
            dWEN <= pwrite;
            dREN <= !pwrite;
        end
    end

    always_ff @(posedge CLK) begin
        if (setup) begin
            req_bank <= paddr[dram_addr_pkg::ADDR_W-1 -: dram_addr_pkg::BANK_W];
            req_row  <= paddr[dram_addr_pkg::COL_W +: dram_addr_pkg::ROW_W];
            req_col  <= paddr[dram_addr_pkg::COL_W-1:0];
        end
    end

    // read data lands one cycle before pready
    // write data reads back until the next read replaces it
    always_ff @(posedge CLK) begin
        if (tRD_done) begin
            prdata <= dram_rdata;
        end else if (setup && pwrite) begin
            prdata <= pwdata;
        end
    end

    a_one_direction: assert property (@(posedge CLK) disable iff (!nRST)
        !(dWEN && dREN));

    a_read_data_ready: assert property (@(posedge CLK) disable iff (!nRST)
        (pready && dREN) |-> $past(tRD_done));

endmodule

//--- command_fsm.sv
`timescale 1ns/100ps

module command_fsm (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   dWEN,
    input  logic                   dREN,
    input  dram_pkg::row_stat_t    row_stat,
    input  logic                   rf_req,
    input  logic                   init_done,
    input  logic                   tACT_done,
    input  logic                   tRD_done,
    input  logic                   tWR_done,
    input  logic                   tPRE_done,
    input  logic                   tREF_done,
    output dram_pkg::cmd_state_t   cmd_state,
    output logic                   ram_wait,
    output logic                   row_resolve,
    output dram_pkg::dram_cmd_t    dram_cmd
);
    dram_pkg::cmd_state_t next_state;
    logic                 nram_wait;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            cmd_state <= dram_pkg::POWER_UP;
            ram_wait  <= 1'b1;
        end else begin
            cmd_state <= next_state;
            ram_wait  <= nram_wait;
        end
    end

    always_comb begin
        next_state  = cmd_state;
        nram_wait   = 1'b1;
        row_resolve = 1'b0;
        case (cmd_state)
            dram_pkg::POWER_UP: begin
                if (init_done) next_state = dram_pkg::IDLE;
            end
            dram_pkg::IDLE: begin
                // refresh always goes through a precharge so no row stays open
                if (rf_req) begin
                    next_state = dram_pkg::PRECHARGE;
                end else if ((dWEN || dREN) && ram_wait) begin
                    // ram_wait low means the last request is just being retired
                    case (row_stat)
                        dram_pkg::ROW_HIT:      next_state = dWEN ? dram_pkg::WRITE
                                                                  : dram_pkg::READ;
                        dram_pkg::ROW_MISS:     next_state = dram_pkg::ACTIVATE;
                        dram_pkg::ROW_CONFLICT: next_state = dram_pkg::PRECHARGE;
                        default:                next_state = dram_pkg::IDLE;
                    endcase
                end
            end
            dram_pkg::ACTIVATE:   next_state = dram_pkg::ACTIVATING;
            dram_pkg::ACTIVATING: begin
                if (tACT_done) begin
                    if (rf_req) next_state = dram_pkg::PRECHARGE;
                    else        next_state = dWEN ? dram_pkg::WRITE : dram_pkg::READ;
                end
            end
            dram_pkg::READ:    next_state = dram_pkg::READING;
            dram_pkg::WRITE:   next_state = dram_pkg::WRITING;
            dram_pkg::READING: begin
                if (tRD_done) begin
                    nram_wait  = 1'b0;
                    next_state = rf_req ? dram_pkg::PRECHARGE : dram_pkg::IDLE;
                end
            end
            dram_pkg::WRITING: begin
                if (tWR_done) begin
                    nram_wait  = 1'b0;
                    next_state = rf_req ? dram_pkg::PRECHARGE : dram_pkg::IDLE;
                end
            end
            dram_pkg::PRECHARGE:   next_state = dram_pkg::PRECHARGING;
            dram_pkg::PRECHARGING: begin
                if (tPRE_done) begin
                    row_resolve = 1'b1;
                    next_state  = rf_req ? dram_pkg::REFRESH : dram_pkg::IDLE;
                end
            end
            dram_pkg::REFRESH:    next_state = dram_pkg::REFRESHING;
            dram_pkg::REFRESHING: begin
                if (tREF_done) next_state = dram_pkg::IDLE;
            end
            default: next_state = dram_pkg::IDLE;
        endcase
    end

    // one command per single-cycle state, a cycle later
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            dram_cmd <= dram_pkg::CMD_NOP;
        end else begin
            case (cmd_state)
                dram_pkg::ACTIVATE:  dram_cmd <= dram_pkg::CMD_ACT;
                dram_pkg::READ:      dram_cmd <= dram_pkg::CMD_RD;
                dram_pkg::WRITE:     dram_cmd <= dram_pkg::CMD_WR;
                dram_pkg::PRECHARGE: dram_cmd <= dram_pkg::CMD_PRE;
                dram_pkg::REFRESH:   dram_cmd <= dram_pkg::CMD_REF;
                default:             dram_cmd <= dram_pkg::CMD_NOP;
            endcase
        end
    end

    // once out of power-up the init flag must have been seen and must stay set
    a_hold_power_up: assert property (@(posedge CLK) disable iff (!nRST)
        cmd_state != dram_pkg::POWER_UP |-> init_done);

endmodule

//--- dram_addr_pkg.sv
package dram_addr_pkg;

    localparam int BANK_W = 2;
    localparam int ROW_W  = 8;
    localparam int COL_W  = 6;
    localparam int DATA_W = 32;

    // host address is {bank, row, col}
    localparam int ADDR_W    = BANK_W + ROW_W + COL_W;
    localparam int NUM_BANKS = 1 << BANK_W;

    typedef logic [BANK_W-1:0] bank_t;
    typedef logic [ROW_W-1:0]  row_t;
    typedef logic [COL_W-1:0]  col_t;
    typedef logic [DATA_W-1:0] data_t;

endpackage

//--- dram_ctrl_top.sv
`timescale 1ns/100ps

module dram_ctrl_top (
    input  logic                              CLK,
    input  logic                              nRST,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [dram_addr_pkg::ADDR_W-1:0]  paddr,
    input  dram_addr_pkg::data_t              pwdata,
    output dram_addr_pkg::data_t              prdata,
    output logic                              pready,
    input  dram_addr_pkg::data_t              dram_rdata,
    output dram_pkg::dram_cmd_t               dram_cmd,
    output dram_addr_pkg::bank_t              dram_bank,
    output dram_addr_pkg::row_t               dram_row,
    output dram_addr_pkg::col_t               dram_col
);
    logic                 dWEN;
    logic                 dREN;
    logic                 ram_wait;
    logic                 row_resolve;
    logic                 rf_req;
    logic                 init_done;
    logic                 tACT_done;
    logic                 tRD_done;
    logic                 tWR_done;
    logic                 tPRE_done;
    logic                 tREF_done;
    dram_addr_pkg::bank_t req_bank;
    dram_addr_pkg::row_t  req_row;
    dram_addr_pkg::col_t  req_col;
    dram_pkg::row_stat_t  row_stat;
    dram_pkg::cmd_state_t cmd_state;

    apb_dram_port u_port (
        .CLK(CLK), .nRST(nRST), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .ram_wait(ram_wait), .dram_rdata(dram_rdata),
        .tRD_done(tRD_done), .prdata(prdata), .pready(pready), .dWEN(dWEN),
        .dREN(dREN), .req_bank(req_bank), .req_row(req_row), .req_col(req_col)
    );

    command_fsm u_fsm (
        .CLK(CLK), .nRST(nRST), .dWEN(dWEN), .dREN(dREN), .row_stat(row_stat),
        .rf_req(rf_req), .init_done(init_done), .tACT_done(tACT_done),
        .tRD_done(tRD_done), .tWR_done(tWR_done), .tPRE_done(tPRE_done),
        .tREF_done(tREF_done), .cmd_state(cmd_state), .ram_wait(ram_wait),
        .row_resolve(row_resolve), .dram_cmd(dram_cmd)
    );

    row_tracker u_rows (
        .CLK(CLK), .nRST(nRST), .cmd_state(cmd_state), .req_bank(req_bank),
        .req_row(req_row), .row_resolve(row_resolve), .row_stat(row_stat)
    );

    timing_counter u_timer (
        .CLK(CLK), .nRST(nRST), .cmd_state(cmd_state), .tACT_done(tACT_done),
        .tRD_done(tRD_done), .tWR_done(tWR_done), .tPRE_done(tPRE_done),
        .tREF_done(tREF_done)
    );

    refresh_scheduler u_refresh (
        .CLK(CLK), .nRST(nRST), .cmd_state(cmd_state), .init_done(init_done),
        .rf_req(rf_req)
    );

    // address goes out in the same cycle as its command
    // a precharge carries the bank of the held request, refresh keeps the last address
    always_ff @(posedge CLK) begin
        if (cmd_state inside {dram_pkg::ACTIVATE, dram_pkg::READ, dram_pkg::WRITE,
                              dram_pkg::PRECHARGE}) begin
            dram_bank <= req_bank;
            dram_row  <= req_row;
            dram_col  <= req_col;
        end
    end

endmodule

//--- dram_pkg.sv
package dram_pkg;

    // command FSM states, the single-cycle states issue one DRAM command each
    typedef enum logic [3:0] {
        POWER_UP,
        IDLE,
        REFRESH,
        REFRESHING,
        ACTIVATE,
        ACTIVATING,
        READ,
        READING,
        WRITE,
        WRITING,
        PRECHARGE,
        PRECHARGING
    } cmd_state_t;

    // codes on the DRAM command port
    typedef enum logic [2:0] {
        CMD_NOP,
        CMD_ACT,
        CMD_RD,
        CMD_WR,
        CMD_PRE,
        CMD_REF
    } dram_cmd_t;

    // open-row status of the pending request
    typedef enum logic [1:0] {
        ROW_IDLE,
        ROW_HIT,
        ROW_MISS,
        ROW_CONFLICT
    } row_stat_t;

    // minimum gaps in clock cycles
    localparam int T_INIT = 40;
    localparam int T_RCD  = 3;
    localparam int T_RD   = 4;
    localparam int T_WR   = 5;
    localparam int T_RP   = 3;
    localparam int T_RFC  = 10;
    localparam int T_REFI = 300;

    // phase counter covers the longest command gap
    localparam int TCNT_W = 4;
    // power-up and refresh interval counter
    localparam int RCNT_W = $clog2((T_REFI > T_INIT ? T_REFI : T_INIT) + 1);

    typedef logic [TCNT_W-1:0] tcnt_t;
    typedef logic [RCNT_W-1:0] rcnt_t;

endpackage

//--- list.f
dram_pkg.sv
dram_addr_pkg.sv
apb_dram_port.sv
command_fsm.sv
row_tracker.sv
timing_counter.sv
refresh_scheduler.sv
dram_ctrl_top.sv
tb_dram_ctrl.sv

//--- refresh_scheduler.sv
`timescale 1ns/100ps

module refresh_scheduler (
    input  logic                   CLK,
    input  logic                   nRST,
    input  dram_pkg::cmd_state_t   cmd_state,
    output logic                   init_done,
    output logic                   rf_req
);
    localparam dram_pkg::rcnt_t INIT_LAST = dram_pkg::rcnt_t'(dram_pkg::T_INIT - 1);
    localparam dram_pkg::rcnt_t REFI_LAST = dram_pkg::rcnt_t'(dram_pkg::T_REFI - 1);

    dram_pkg::rcnt_t init_cnt;
    dram_pkg::rcnt_t refi_cnt;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            init_cnt  <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            if (init_cnt == INIT_LAST) init_done <= 1'b1;
            else                       init_cnt  <= init_cnt + 1'b1;
        end
    end

    // interval restarts on each refresh and saturates while the request waits
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            refi_cnt <= '0;
        end else if (!init_done || cmd_state == dram_pkg::REFRESH) begin
            refi_cnt <= '0;
        end else if (refi_cnt != REFI_LAST) begin
            refi_cnt <= refi_cnt + 1'b1;
        end
    end

    assign rf_req = (refi_cnt == REFI_LAST);

endmodule

//--- row_tracker.sv
`timescale 1ns/100ps

module row_tracker (
    input  logic                   CLK,
    input  logic                   nRST,
    input  dram_pkg::cmd_state_t   cmd_state,
    input  dram_addr_pkg::bank_t   req_bank,
    input  dram_addr_pkg::row_t    req_row,
    input  logic                   row_resolve,
    output dram_pkg::row_stat_t    row_stat
);
    logic [dram_addr_pkg::NUM_BANKS-1:0] bank_open;
    dram_addr_pkg::row_t                 open_row [dram_addr_pkg::NUM_BANKS];

    // a refresh closes every bank, a finished precharge closes the requested one
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            bank_open <= '0;
        end else if (cmd_state == dram_pkg::REFRESH) begin
            bank_open <= '0;
        end else if (cmd_state == dram_pkg::ACTIVATE) begin
            bank_open[req_bank] <= 1'b1;
        end else if (row_resolve) begin
            bank_open[req_bank] <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (cmd_state == dram_pkg::ACTIVATE) begin
            open_row[req_bank] <= req_row;
        end
    end

    always_comb begin
        if (cmd_state inside {dram_pkg::POWER_UP, dram_pkg::REFRESH,
                              dram_pkg::REFRESHING}) begin
            // table is being reset, no valid status
            row_stat = dram_pkg::ROW_IDLE;
        end else if (!bank_open[req_bank]) begin
            row_stat = dram_pkg::ROW_MISS;
        end else if (open_row[req_bank] == req_row) begin
            row_stat = dram_pkg::ROW_HIT;
        end else begin
            row_stat = dram_pkg::ROW_CONFLICT;
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the DRAM controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module tb_dram_ctrl \
        -f list.f -o Vtb_dram_ctrl; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_dram_ctrl > sim.log 2>&1
status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "all tests passed" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- tb_dram_ctrl.sv
`timescale 1ns/100ps

module tb_dram_ctrl;

    localparam int RST_CYCLES = 10;
    localparam int NUM_REQ    = 40;
    // conflict request cut short by a refresh, plus state hand-over cycles
    localparam int REQ_MAX    = 2 * (dram_pkg::T_RP + 2) + (dram_pkg::T_RCD + 2)
                                + (dram_pkg::T_WR + 2) + 6;
    localparam int REF_LIMIT  = dram_pkg::T_REFI + REQ_MAX;
    localparam int REF_TIME   = dram_pkg::T_RP + dram_pkg::T_RFC + 4;
    localparam int XFER_MAX   = REQ_MAX + 4;
    localparam int TIMEOUT    = RST_CYCLES + dram_pkg::T_INIT + NUM_REQ * XFER_MAX
                                + (NUM_REQ * XFER_MAX / dram_pkg::T_REFI + 1) * REF_TIME;
    localparam logic [31:0] SEED = 32'h2fb05706;

    logic                             CLK;
    logic                             nRST;
    logic                             psel;
    logic                             penable;
    logic                             pwrite;
    logic [dram_addr_pkg::ADDR_W-1:0] paddr;
    dram_addr_pkg::data_t             pwdata;
    dram_addr_pkg::data_t             prdata;
    logic                             pready;
    dram_addr_pkg::data_t             dram_rdata = '0;
    dram_pkg::dram_cmd_t              dram_cmd;
    dram_addr_pkg::bank_t             dram_bank;
    dram_addr_pkg::row_t              dram_row;
    dram_addr_pkg::col_t              dram_col;

    // request in flight, as issued by the host
    logic                             cur_write;
    dram_addr_pkg::bank_t             cur_bank;
    dram_addr_pkg::row_t              cur_row;
    dram_addr_pkg::col_t              cur_col;

    // bank state as seen on the command port
    logic [dram_addr_pkg::NUM_BANKS-1:0] open_bank;
    dram_addr_pkg::row_t                 open_row [dram_addr_pkg::NUM_BANKS];
    dram_pkg::dram_cmd_t                 last_cmd;
    int                                  gap;
    int                                  need_gap;
    int                                  since_rst;
    int                                  since_ref;
    int                                  ref_count;
    int                                  ready_count;
    int                                  cycle_count = 0;
    dram_addr_pkg::data_t                exp_rdata;
    dram_addr_pkg::data_t                act_exp;
    dram_addr_pkg::data_t                act_got;
    dram_addr_pkg::data_t                acc_exp;
    dram_addr_pkg::data_t                acc_got;

    dram_ctrl_top dut (
        .CLK(CLK), .nRST(nRST), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .dram_rdata(dram_rdata), .dram_cmd(dram_cmd), .dram_bank(dram_bank),
        .dram_row(dram_row), .dram_col(dram_col)
    );

    // DRAM read data is a fixed pattern of the column
    function automatic dram_addr_pkg::data_t rdata_of(input dram_addr_pkg::col_t col);
        return {8'hc5, col, ~col, col ^ 6'h2a, 6'h15};
    endfunction

    function automatic int min_gap(input dram_pkg::dram_cmd_t cmd);
        case (cmd)
            dram_pkg::CMD_ACT: return dram_pkg::T_RCD;
            dram_pkg::CMD_RD:  return dram_pkg::T_RD;
            dram_pkg::CMD_WR:  return dram_pkg::T_WR;
            dram_pkg::CMD_PRE: return dram_pkg::T_RP;
            dram_pkg::CMD_REF: return dram_pkg::T_RFC;
            default:           return 0;
        endcase
    endfunction

    task automatic report_value(input string name, input dram_addr_pkg::data_t expected,
                                input dram_addr_pkg::data_t actual);
        $display("Error %s: expected %0h, actual %0h", name, expected, actual);
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_failure(input string what);
        $display("Error: %s", what);
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    // one APB transfer, held until pready
    task automatic run_transfer(input logic wr, input dram_addr_pkg::bank_t bank,
                                input dram_addr_pkg::row_t row,
                                input dram_addr_pkg::col_t col,
                                input dram_addr_pkg::data_t data);
        @(posedge CLK);
        psel      <= 1'b1;
        penable   <= 1'b0;
        pwrite    <= wr;
        paddr     <= {bank, row, col};
        pwdata    <= data;
        cur_write <= wr;
        cur_bank  <= bank;
        cur_row   <= row;
        cur_col   <= col;
        @(posedge CLK);
        penable <= 1'b1;
        @(posedge CLK);
        while (!pready) @(posedge CLK);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        if (dram_cmd == dram_pkg::CMD_RD) dram_rdata <= rdata_of(dram_col);
    end

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT)
            report_failure($sformatf("run did not finish within %0d cycles", TIMEOUT));
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            open_bank   <= '0;
            last_cmd    <= dram_pkg::CMD_NOP;
            gap         <= 0;
            since_rst   <= 0;
            since_ref   <= 0;
            ref_count   <= 0;
            ready_count <= 0;
        end else begin
            since_rst <= since_rst + 1;
            if (pready) ready_count <= ready_count + 1;
            if (dram_cmd != dram_pkg::CMD_NOP) begin
                last_cmd <= dram_cmd;
                gap      <= 1;
            end else begin
                gap <= gap + 1;
            end
            // interval is counted from the end of power-up
            if (since_rst < dram_pkg::T_INIT || dram_cmd == dram_pkg::CMD_REF)
                since_ref <= 0;
            else
                since_ref <= since_ref + 1;
            case (dram_cmd)
                dram_pkg::CMD_ACT: begin
                    open_bank[dram_bank] <= 1'b1;
                    open_row[dram_bank]  <= dram_row;
                end
                dram_pkg::CMD_PRE: open_bank[dram_bank] <= 1'b0;
                dram_pkg::CMD_REF: begin
                    open_bank <= '0;
                    ref_count <= ref_count + 1;
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        need_gap  = min_gap(last_cmd);
        exp_rdata = rdata_of(cur_col);
        act_exp   = dram_addr_pkg::data_t'({cur_bank, cur_row});
        act_got   = dram_addr_pkg::data_t'({dram_bank, dram_row});
        acc_exp   = dram_addr_pkg::data_t'({cur_write, cur_bank, cur_row, cur_col});
        acc_got   = dram_addr_pkg::data_t'({dram_cmd == dram_pkg::CMD_WR, dram_bank,
                                            dram_row, dram_col});
    end

    a_quiet_init: assert property (@(posedge CLK) disable iff (!nRST)
        since_rst < dram_pkg::T_INIT |-> dram_cmd == dram_pkg::CMD_NOP && !pready)
        else report_failure("command or pready seen before power-up ended");

    a_act_closed: assert property (@(posedge CLK) disable iff (!nRST)
        dram_cmd == dram_pkg::CMD_ACT |-> !open_bank[dram_bank])
        else report_failure("ACT issued to a bank that still has an open row");

    a_act_addr: assert property (@(posedge CLK) disable iff (!nRST)
        dram_cmd == dram_pkg::CMD_ACT |-> act_got == act_exp)
        else report_value("activate address", $sampled(act_exp), $sampled(act_got));

    a_access_open: assert property (@(posedge CLK) disable iff (!nRST)
        dram_cmd inside {dram_pkg::CMD_RD, dram_pkg::CMD_WR}
        |-> open_bank[dram_bank] && open_row[dram_bank] == dram_row)
        else report_failure("read or write issued to a row that is not open");

    a_access_addr: assert property (@(posedge CLK) disable iff (!nRST)
        dram_cmd inside {dram_pkg::CMD_RD, dram_pkg::CMD_WR} |-> acc_got == acc_exp)
        else report_value("access command", $sampled(acc_exp), $sampled(acc_got));

    a_cmd_gap: assert property (@(posedge CLK) disable iff (!nRST)
        dram_cmd != dram_pkg::CMD_NOP |-> gap >= need_gap)
        else report_value("command spacing", $sampled(need_gap), $sampled(gap));

    a_single_cmd: assert property (@(posedge CLK) disable iff (!nRST)
        dram_cmd != dram_pkg::CMD_NOP |=> dram_cmd == dram_pkg::CMD_NOP)
        else report_failure("two commands issued in consecutive cycles");

    a_ref_after_pre: assert property (@(posedge CLK) disable iff (!nRST)
        (dram_cmd == dram_pkg::CMD_REF && open_bank != '0) |-> last_cmd == dram_pkg::CMD_PRE)
        else report_failure("REF issued with a row open and no PRE before it");

    a_ref_interval: assert property (@(posedge CLK) disable iff (!nRST)
        since_ref < REF_LIMIT)
        else report_failure("no REF within the refresh interval");

    a_read_data: assert property (@(posedge CLK) disable iff (!nRST)
        (pready && !cur_write) |-> prdata == exp_rdata)
        else report_value("read data", $sampled(exp_rdata), $sampled(prdata));

    a_ready_pulse: assert property (@(posedge CLK) disable iff (!nRST)
        pready |=> !pready)
        else report_failure("pready held high for more than one cycle");

    a_ready_in_access: assert property (@(posedge CLK) disable iff (!nRST)
        pready |-> psel && penable)
        else report_failure("pready raised outside an APB access phase");

    initial begin
        dram_addr_pkg::bank_t bank;
        dram_addr_pkg::row_t  row;
        dram_addr_pkg::col_t  col;
        logic                 wr;

        void'($urandom(SEED));
        nRST      = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        cur_write = 1'b0;
        cur_bank  = '0;
        cur_row   = '0;
        cur_col   = '0;
        repeat (RST_CYCLES) @(posedge CLK);
        nRST <= 1'b1;

        // two rows per bank so that hits and conflicts both come up often
        for (int i = 0; i < NUM_REQ; i++) begin
            bank = dram_addr_pkg::bank_t'($urandom_range(0, dram_addr_pkg::NUM_BANKS - 1));
            row  = ($urandom_range(0, 1) == 1) ? 8'h5a : 8'ha5;
            col  = dram_addr_pkg::col_t'($urandom());
            wr   = ($urandom_range(0, 1) == 1);
            run_transfer(wr, bank, row, col, $urandom());
        end
        repeat (5) @(posedge CLK);

        if (ref_count == 0) begin
            report_failure("no REF command was issued during the run");
        end else if (ready_count != NUM_REQ) begin
            report_value("transfer count", NUM_REQ, ready_count);
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

//--- timing_counter.sv
`timescale 1ns/100ps

module timing_counter (
    input  logic                   CLK,
    input  logic                   nRST,
    input  dram_pkg::cmd_state_t   cmd_state,
    output logic                   tACT_done,
    output logic                   tRD_done,
    output logic                   tWR_done,
    output logic                   tPRE_done,
    output logic                   tREF_done
);
    dram_pkg::tcnt_t      cnt;
    dram_pkg::cmd_state_t phase;
    logic                 expire;

    // load on the command state, count down while the FSM waits
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            cnt   <= '0;
            phase <= dram_pkg::IDLE;
        end else begin
            phase <= (cmd_state inside {dram_pkg::ACTIVATE, dram_pkg::READ, dram_pkg::WRITE,
                                        dram_pkg::PRECHARGE, dram_pkg::REFRESH})
                     ? cmd_state : phase;
            case (cmd_state)
                dram_pkg::ACTIVATE:  cnt <= dram_pkg::tcnt_t'(dram_pkg::T_RCD);
                dram_pkg::READ:      cnt <= dram_pkg::tcnt_t'(dram_pkg::T_RD);
                dram_pkg::WRITE:     cnt <= dram_pkg::tcnt_t'(dram_pkg::T_WR);
                dram_pkg::PRECHARGE: cnt <= dram_pkg::tcnt_t'(dram_pkg::T_RP);
                dram_pkg::REFRESH:   cnt <= dram_pkg::tcnt_t'(dram_pkg::T_RFC);
                default: begin
                    if (cnt != '0) cnt <= cnt - 1'b1;
                end
            endcase
        end
    end

    // last cycle of the count, the FSM moves on at the next edge
    assign expire = (cnt == dram_pkg::tcnt_t'(1));

    assign tACT_done = expire && (phase == dram_pkg::ACTIVATE);
    assign tRD_done  = expire && (phase == dram_pkg::READ);
    assign tWR_done  = expire && (phase == dram_pkg::WRITE);
    assign tPRE_done = expire && (phase == dram_pkg::PRECHARGE);
    assign tREF_done = expire && (phase == dram_pkg::REFRESH);

    a_single_done: assert property (@(posedge CLK) disable iff (!nRST)
        $onehot0({tACT_done, tRD_done, tWR_done, tPRE_done, tREF_done}));

endmodule
